// ==== hdl/cdc_sync_bits.sv ====
// ##########################################################################
// Two-flop synchronizer for quasi-static levels of any packed type.
// ##########################################################################
`timescale 1ns/1ps
`default_nettype none

module cdc_sync_bits #(
  parameter type T = logic
) (
  input  logic out_clk,
  input  T     in_bits,
  output T     out_bits
);

  T meta_q;
  T sync_q;

  // bits of a changing multi-bit value may land one cycle apart.
  always_ff @(posedge out_clk) begin
    meta_q <= in_bits;
    sync_q <= meta_q;
  end

  assign out_bits = sync_q;

endmodule

`default_nettype wire

// ==== hdl/cdc_sync_pulse.sv ====
// ##########################################################################
// Single-pulse crossing between two clocks.
// A toggle in the source domain becomes one pulse in the destination.
// ##########################################################################
`timescale 1ns/1ps
`default_nettype none

module cdc_sync_pulse (
  input  logic in_clk,
  input  logic in_reset,
  input  logic in_pulse,
  input  logic out_clk,
  input  logic out_reset,
  output logic out_pulse
);

  logic in_toggle_q;
  logic out_meta_q;
  logic out_sync_q;
  logic out_last_q;

  always_ff @(posedge in_clk) begin
    if (in_reset) begin
      in_toggle_q <= 1'b0;
    end else if (in_pulse) begin
      in_toggle_q <= ~in_toggle_q;
    end
  end

  always_ff @(posedge out_clk) begin
    if (out_reset) begin
      out_meta_q <= 1'b0;
      out_sync_q <= 1'b0;
      out_last_q <= 1'b0;
    end else begin
      out_meta_q <= in_toggle_q;
      out_sync_q <= out_meta_q;
      out_last_q <= out_sync_q;
    end
  end

  // each change of the synchronized toggle is one event.
  assign out_pulse = out_sync_q ^ out_last_q;

endmodule

`default_nettype wire

// ==== hdl/jesd_tx_cdc.sv ====
// ##########################################################################
// JESD204 transmit control clock crossing.
// Configuration moves to core_clk, status and SYNC move back to up_clk.
// ##########################################################################
`timescale 1ns/1ps
`default_nettype none
`include "jesd_tx_cfg.svh"

module jesd_tx_cdc (
  input  logic up_clk,
  input  logic up_reset,
  input  logic core_clk,
  input  logic core_reset,
  jesd_tx_ctrl_if.ctrl_dst up_side,
  jesd_tx_ctrl_if.ctrl_src core_side
);

  cdc_sync_bits #(.T(jesd_tx_pkg::tx_opts_t)) opts_sync0 (
    .out_clk  (core_clk),
    .in_bits  (up_side.opts),
    .out_bits (core_side.opts)
  );

  // the ILAS words only change while the link is held off.
  for (genvar i = 0; i < `JESD_NUM_LANES; i++) begin : g_lane
    cdc_sync_bits #(.T(jesd_tx_pkg::lane_ilas_t)) ilas_sync0 (
      .out_clk  (core_clk),
      .in_bits  (up_side.ilas[i]),
      .out_bits (core_side.ilas[i])
    );
  end

  cdc_sync_bits #(.T(jesd_tx_pkg::link_state_t)) state_sync0 (
    .out_clk  (up_clk),
    .in_bits  (core_side.status_state),
    .out_bits (up_side.status_state)
  );

  cdc_sync_bits #(.T(logic [`JESD_NUM_LINKS-1:0])) link_sync0 (
    .out_clk  (up_clk),
    .in_bits  (core_side.status_sync),
    .out_bits (up_side.status_sync)
  );

  cdc_sync_pulse req_sync0 (
    .in_clk    (up_clk),
    .in_reset  (up_reset),
    .in_pulse  (up_side.sync_request),
    .out_clk   (core_clk),
    .out_reset (core_reset),
    .out_pulse (core_side.sync_request)
  );

endmodule

`default_nettype wire

// ==== hdl/jesd_tx_cfg.svh ====
// ##########################################################################
// JESD204 transmit control plane configuration.
// Lane and link counts, multiframe length and register word addresses.
// ##########################################################################
`ifndef JESD_TX_CFG_SVH
`define JESD_TX_CFG_SVH

`define JESD_NUM_LANES 2
`define JESD_NUM_LINKS 1
`define JESD_BEATS_PER_MFRAME 4

`define JESD_REG_CFG 12'h090
`define JESD_REG_MFRAMES 12'h091
`define JESD_REG_SYNC_REQ 12'h092
`define JESD_REG_STATUS 12'h0A0
`define JESD_REG_ILAS_BASE 12'h0C4

`endif

// ==== hdl/jesd_tx_ctrl_if.sv ====
// ##########################################################################
// JESD204 transmit control interface.
// Configuration toward the link, status back toward the processor.
// ##########################################################################
`timescale 1ns/1ps
`default_nettype none
`include "jesd_tx_cfg.svh"

interface jesd_tx_ctrl_if;

  jesd_tx_pkg::tx_opts_t    opts;
  jesd_tx_pkg::lane_ilas_t  ilas [`JESD_NUM_LANES];
  logic                     sync_request;
  jesd_tx_pkg::link_state_t status_state;
  logic [`JESD_NUM_LINKS-1:0] status_sync;

  // the configuration side drives options and requests.
  modport ctrl_src (output opts, output ilas, output sync_request,
                    input status_state, input status_sync);

  // the link side reports its state and the raw SYNC lines.
  modport ctrl_dst (input opts, input ilas, input sync_request,
                    output status_state, output status_sync);

endinterface

`default_nettype wire

// ==== hdl/jesd_tx_link.sv ====
// ##########################################################################
// JESD204 transmit link sequencer.
// Runs CGS, ILAS and DATA and drives registered per-lane 32-bit words.
// ##########################################################################
`timescale 1ns/1ps
`default_nettype none
`include "jesd_tx_cfg.svh"

module jesd_tx_link (
  input  logic                            core_clk,
  input  logic                            core_reset,
  input  logic [`JESD_NUM_LINKS-1:0]      sync,
  input  logic [32*`JESD_NUM_LANES-1:0]   tx_data,
  output logic [32*`JESD_NUM_LANES-1:0]   lane_data,
  output jesd_tx_pkg::link_state_t        lane_state,
  jesd_tx_ctrl_if.ctrl_dst ctrl
);

  localparam int BEAT_W = $clog2(`JESD_BEATS_PER_MFRAME);
  localparam logic [BEAT_W-1:0] LAST_BEAT = BEAT_W'(`JESD_BEATS_PER_MFRAME - 1);

  jesd_tx_pkg::link_state_t      state_q;
  logic [BEAT_W-1:0]             beat_q;
  logic [7:0]                    mframe_q;
  logic [`JESD_NUM_LINKS-1:0]    sync_prev_q;
  logic                          sync_lost;
  logic [32*`JESD_NUM_LANES-1:0] lane_next;

  assign sync_lost = |(sync_prev_q & ~sync);

  always_ff @(posedge core_clk) begin
    if (core_reset) begin
      state_q     <= jesd_tx_pkg::LINK_CGS;
      beat_q      <= '0;
      mframe_q    <= '0;
      sync_prev_q <= '0;
    end else begin
      sync_prev_q <= sync;
      if (sync_lost || ctrl.sync_request) begin
        state_q  <= jesd_tx_pkg::LINK_CGS;
        beat_q   <= '0;
        mframe_q <= '0;
      end else begin
        case (state_q)
          jesd_tx_pkg::LINK_CGS: begin
            beat_q   <= '0;
            mframe_q <= '0;
            if (&sync && !ctrl.opts.continuous_cgs) begin
              state_q <= ctrl.opts.skip_ilas ? jesd_tx_pkg::LINK_DATA
                                             : jesd_tx_pkg::LINK_ILAS;
            end
          end
          jesd_tx_pkg::LINK_ILAS: begin
            beat_q <= beat_q + 1'b1;
            if (beat_q == LAST_BEAT) begin
              beat_q <= '0;
              if (mframe_q == ctrl.opts.mframes_per_ilas) begin
                mframe_q <= '0;
                // continuous ILAS restarts at the first multiframe.
                if (!ctrl.opts.continuous_ilas) begin
                  state_q <= jesd_tx_pkg::LINK_DATA;
                end
              end else begin
                mframe_q <= mframe_q + 1'b1;
              end
            end
          end
          default: state_q <= jesd_tx_pkg::LINK_DATA;
        endcase
      end
    end
  end

  always_comb begin
    for (int i = 0; i < `JESD_NUM_LANES; i++) begin
      case (state_q)
        jesd_tx_pkg::LINK_ILAS: begin
          if (mframe_q == 8'd1) begin
            lane_next[i*32 +: 32] = ctrl.ilas[i][beat_q];
          end else if (beat_q == '0) begin
            lane_next[i*32 +: 32] = {4{jesd_tx_pkg::K_RSTART}};
          end else if (beat_q == LAST_BEAT) begin
            lane_next[i*32 +: 32] = {4{jesd_tx_pkg::K_AEND}};
          end else begin
            lane_next[i*32 +: 32] = 32'h0;
          end
        end
        jesd_tx_pkg::LINK_DATA: lane_next[i*32 +: 32] = tx_data[i*32 +: 32];
        default: lane_next[i*32 +: 32] = {4{jesd_tx_pkg::K_CGS}};
      endcase
    end
  end

  // lane words trail the sequencer by one cycle.
  always_ff @(posedge core_clk) begin
    if (core_reset) begin
      lane_data  <= {4*`JESD_NUM_LANES{jesd_tx_pkg::K_CGS}};
      lane_state <= jesd_tx_pkg::LINK_CGS;
    end else begin
      lane_data  <= lane_next;
      lane_state <= state_q;
    end
  end

  assign ctrl.status_state = state_q;
  assign ctrl.status_sync  = sync;

endmodule

`default_nettype wire

// ==== hdl/jesd_tx_pkg.sv ====
// ##########################################################################
// JESD204 transmit control plane types.
// Link state encoding, link options, ILAS words and control characters.
// ##########################################################################
`default_nettype none

package jesd_tx_pkg;

  // state encoding matches the status register field.
  typedef enum logic [1:0] {
    LINK_CGS  = 2'd0,
    LINK_ILAS = 2'd1,
    LINK_DATA = 2'd2
  } link_state_t;

  // the ILAS lasts mframes_per_ilas plus one multiframes.
  typedef struct packed {
    logic       skip_ilas;
    logic       continuous_ilas;
    logic       continuous_cgs;
    logic [7:0] mframes_per_ilas;
  } tx_opts_t;

  typedef logic [31:0] ilas_word_t;

  // four configuration words sent in the second ILAS multiframe.
  typedef ilas_word_t [3:0] lane_ilas_t;

  localparam logic [7:0] K_CGS    = 8'hBC;
  localparam logic [7:0] K_RSTART = 8'h1C;
  localparam logic [7:0] K_AEND   = 8'h7C;

endpackage

`default_nettype wire

// ==== hdl/jesd_tx_regmap.sv ====
// ##########################################################################
// JESD204 transmit register map.
// Link options, ILAS configuration fields per lane window and status.
// ##########################################################################
`timescale 1ns/1ps
`default_nettype none
`include "jesd_tx_cfg.svh"

module jesd_tx_regmap (
  input  logic        up_clk,
  input  logic        up_reset,
  input  logic [11:0] up_raddr,
  input  logic [11:0] up_waddr,
  input  logic        up_wreq,
  input  logic [31:0] up_wdata,
  input  logic        up_cfg_is_writeable,
  output logic [31:0] up_rdata,
  jesd_tx_ctrl_if.ctrl_src ctrl
);

  jesd_tx_pkg::tx_opts_t   opts_q;
  logic                    sync_req_q;
  jesd_tx_pkg::lane_ilas_t ilas_words [`JESD_NUM_LANES];
  logic [11:0]             rd_off;
  logic [11:0]             wr_off;

  // the shared fields are reachable through every lane window.
  logic [7:0] did_q;
  logic [3:0] bid_q;
  logic [4:0] l_q;
  logic       scr_q;
  logic [7:0] f_q;
  logic [4:0] k_q;
  logic [7:0] m_q;
  logic [4:0] n_q;
  logic [1:0] cs_q;
  logic [4:0] np_q;
  logic [2:0] subclass_q;
  logic [4:0] s_q;
  logic [2:0] jesdv_q;
  logic [4:0] cf_q;
  logic       hd_q;

  logic [4:0] lid_q  [`JESD_NUM_LANES];
  logic [7:0] fchk_q [`JESD_NUM_LANES];

  // offsets below the base wrap high and miss every window.
  assign rd_off = up_raddr - `JESD_REG_ILAS_BASE;
  assign wr_off = up_waddr - `JESD_REG_ILAS_BASE;

  // fields sit at the positions of the configuration octets.
  always_comb begin
    for (int i = 0; i < `JESD_NUM_LANES; i++) begin
      ilas_words[i][0] = {4'b0000, bid_q, did_q, 16'h0000};
      ilas_words[i][1] = {3'b000, k_q, f_q, scr_q, 2'b00, l_q, 3'b000, lid_q[i]};
      ilas_words[i][2] = {jesdv_q, s_q, subclass_q, np_q, cs_q, 1'b0, n_q, m_q};
      ilas_words[i][3] = {fchk_q[i], 16'h0000, hd_q, 2'b00, cf_q};
    end
  end

  always_comb begin
    up_rdata = 32'h0;
    case (up_raddr)
      `JESD_REG_CFG: up_rdata = {29'h0, opts_q.skip_ilas, opts_q.continuous_ilas,
                                 opts_q.continuous_cgs};
      `JESD_REG_MFRAMES: up_rdata = {24'h0, opts_q.mframes_per_ilas};
      `JESD_REG_STATUS: up_rdata = {20'h0, 8'(ctrl.status_sync), 2'b00, ctrl.status_state};
      default: begin
        for (int i = 0; i < `JESD_NUM_LANES; i++) begin
          if (rd_off[11:2] == 10'(2 * i)) begin
            up_rdata = ilas_words[i][rd_off[1:0]];
          end
        end
      end
    endcase
  end

  always_ff @(posedge up_clk) begin
    if (up_reset) begin
      opts_q <= '{skip_ilas: 1'b0, continuous_ilas: 1'b0, continuous_cgs: 1'b0,
                  mframes_per_ilas: 8'd3};
      {did_q, bid_q, l_q, scr_q, f_q, k_q, m_q, n_q} <= '0;
      {cs_q, np_q, subclass_q, s_q, jesdv_q, cf_q, hd_q} <= '0;
      for (int i = 0; i < `JESD_NUM_LANES; i++) begin
        lid_q[i]  <= '0;
        fchk_q[i] <= '0;
      end
    end else if (up_wreq && up_cfg_is_writeable) begin
      if (up_waddr == `JESD_REG_CFG) begin
        opts_q.skip_ilas       <= up_wdata[2];
        opts_q.continuous_ilas <= up_wdata[1];
        opts_q.continuous_cgs  <= up_wdata[0];
      end
      if (up_waddr == `JESD_REG_MFRAMES) begin
        opts_q.mframes_per_ilas <= up_wdata[7:0];
      end
      for (int i = 0; i < `JESD_NUM_LANES; i++) begin
        if (wr_off[11:2] == 10'(2 * i)) begin
          case (wr_off[1:0])
            2'd0: begin
              bid_q <= up_wdata[27:24];
              did_q <= up_wdata[23:16];
            end
            2'd1: begin
              k_q      <= up_wdata[28:24];
              f_q      <= up_wdata[23:16];
              scr_q    <= up_wdata[15];
              l_q      <= up_wdata[12:8];
              lid_q[i] <= up_wdata[4:0];
            end
            2'd2: begin
              {jesdv_q, s_q, subclass_q, np_q, cs_q} <= up_wdata[31:14];
              n_q <= up_wdata[12:8];
              m_q <= up_wdata[7:0];
            end
            default: begin
              fchk_q[i] <= up_wdata[31:24];
              hd_q      <= up_wdata[7];
              cf_q      <= up_wdata[4:0];
            end
          endcase
        end
      end
    end
  end

  // the request register ignores the writeable gate and clears itself.
  always_ff @(posedge up_clk) begin
    if (up_reset) begin
      sync_req_q <= 1'b0;
    end else begin
      sync_req_q <= up_wreq && (up_waddr == `JESD_REG_SYNC_REQ) && up_wdata[0];
    end
  end

  assign ctrl.opts         = opts_q;
  assign ctrl.ilas         = ilas_words;
  assign ctrl.sync_request = sync_req_q;

endmodule

`default_nettype wire

// ==== hdl/jesd_tx_up_top.sv ====
// ##########################################################################
// JESD204 transmit control plane top level.
// Register map on up_clk, clock crossing and link sequencer on core_clk.
// ##########################################################################
`timescale 1ns/1ps
`default_nettype none
`include "jesd_tx_cfg.svh"

module jesd_tx_up_top (
  input  logic                          up_clk,
  input  logic                          up_reset,
  input  logic [11:0]                   up_raddr,
  output logic [31:0]                   up_rdata,
  input  logic                          up_wreq,
  input  logic [11:0]                   up_waddr,
  input  logic [31:0]                   up_wdata,
  input  logic                          up_cfg_is_writeable,
  input  logic                          core_clk,
  input  logic                          core_reset,
  input  logic [`JESD_NUM_LINKS-1:0]    sync,
  input  logic [32*`JESD_NUM_LANES-1:0] tx_data,
  output logic [32*`JESD_NUM_LANES-1:0] lane_data,
  output jesd_tx_pkg::link_state_t      lane_state
);

  // one control bundle per clock domain.
  jesd_tx_ctrl_if up_ctrl ();
  jesd_tx_ctrl_if core_ctrl ();

  jesd_tx_regmap regmap0 (
    .up_clk              (up_clk),
    .up_reset            (up_reset),
    .up_raddr            (up_raddr),
    .up_waddr            (up_waddr),
    .up_wreq             (up_wreq),
    .up_wdata            (up_wdata),
    .up_cfg_is_writeable (up_cfg_is_writeable),
    .up_rdata            (up_rdata),
    .ctrl                (up_ctrl.ctrl_src)
  );

  jesd_tx_cdc cdc0 (
    .up_clk     (up_clk),
    .up_reset   (up_reset),
    .core_clk   (core_clk),
    .core_reset (core_reset),
    .up_side    (up_ctrl.ctrl_dst),
    .core_side  (core_ctrl.ctrl_src)
  );

  jesd_tx_link link0 (
    .core_clk   (core_clk),
    .core_reset (core_reset),
    .sync       (sync),
    .tx_data    (tx_data),
    .lane_data  (lane_data),
    .lane_state (lane_state),
    .ctrl       (core_ctrl.ctrl_dst)
  );

endmodule

`default_nettype wire

// ==== jesd_tx_up.f ====
+incdir+hdl
hdl/jesd_tx_pkg.sv
hdl/jesd_tx_ctrl_if.sv
hdl/cdc_sync_bits.sv
hdl/cdc_sync_pulse.sv
hdl/jesd_tx_regmap.sv
hdl/jesd_tx_cdc.sv
hdl/jesd_tx_link.sv
hdl/jesd_tx_up_top.sv
tb/jesd_tx_up_sva.sv
tb/tb_jesd_tx_up.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds and runs the JESD204 transmit control plane testbench with Verilator.
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f jesd_tx_up.f --top-module tb_jesd_tx_up
# The testbench counts assertion errors itself, so they must not end the run early.
./obj_dir/Vtb_jesd_tx_up +verilator+error+limit+1000 2>&1 | tee sim.log
if grep -q "TEST RESULT: PASS" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

// ==== tb/jesd_tx_up_sva.sv ====
// ##########################################################################
// Assertions on the lane words of the JESD204 transmit link.
// Bound to the control plane top level.
// ##########################################################################
`timescale 1ns/1ps
`default_nettype none
`include "jesd_tx_cfg.svh"

module jesd_tx_up_sva (
  input logic                          core_clk,
  input logic                          core_reset,
  input logic [32*`JESD_NUM_LANES-1:0] tx_data,
  input logic [32*`JESD_NUM_LANES-1:0] lane_data,
  input jesd_tx_pkg::link_state_t      lane_state,
  input jesd_tx_pkg::tx_opts_t         opts
);

  int          fail_cgs = 0;
  int          fail_ilas = 0;
  int          fail_data = 0;
  int          fail_hold = 0;
  int          fail_count;
  logic [1:0]  beat_c;
  logic [7:0]  mf_c;
  logic [31:0] marker;

  assign fail_count = fail_cgs + fail_ilas + fail_data + fail_hold;

  // beat and multiframe of the word currently shown on lane_data.
  always_ff @(posedge core_clk) begin
    if (core_reset || lane_state != jesd_tx_pkg::LINK_ILAS) begin
      beat_c <= '0;
      mf_c   <= '0;
    end else begin
      beat_c <= beat_c + 2'd1;
      if (beat_c == 2'd3) begin
        mf_c <= (mf_c == opts.mframes_per_ilas) ? 8'd0 : mf_c + 8'd1;
      end
    end
  end

  always_comb begin
    case (beat_c)
      2'd0: marker = {4{jesd_tx_pkg::K_RSTART}};
      2'd3: marker = {4{jesd_tx_pkg::K_AEND}};
      default: marker = 32'h0;
    endcase
  end

  cgs_words: assert property (@(posedge core_clk) disable iff (core_reset)
    lane_state == jesd_tx_pkg::LINK_CGS |->
      lane_data == {4*`JESD_NUM_LANES{jesd_tx_pkg::K_CGS}})
    else begin
      fail_cgs++;
      $error("lane words in CGS are not all K_CGS characters");
    end

  // the configuration multiframe is checked by the testbench.
  ilas_markers: assert property (@(posedge core_clk) disable iff (core_reset)
    lane_state == jesd_tx_pkg::LINK_ILAS && mf_c != 8'd1 |->
      lane_data == {`JESD_NUM_LANES{marker}})
    else begin
      fail_ilas++;
      $error("ILAS marker word is wrong at beat %0d of multiframe %0d", beat_c, mf_c);
    end

  data_follows: assert property (@(posedge core_clk) disable iff (core_reset)
    lane_state == jesd_tx_pkg::LINK_DATA |-> lane_data == $past(tx_data))
    else begin
      fail_data++;
      $error("lane words in DATA do not follow tx_data of the previous cycle");
    end

  cgs_held: assert property (@(posedge core_clk) disable iff (core_reset)
    opts.continuous_cgs && $past(opts.continuous_cgs) &&
      lane_state == jesd_tx_pkg::LINK_CGS |=> lane_state == jesd_tx_pkg::LINK_CGS)
    else begin
      fail_hold++;
      $error("link left CGS while continuous CGS was set");
    end

endmodule

bind jesd_tx_up_top jesd_tx_up_sva sva0 (
  .core_clk   (core_clk),
  .core_reset (core_reset),
  .tx_data    (tx_data),
  .lane_data  (lane_data),
  .lane_state (lane_state),
  .opts       (core_ctrl.opts)
);

`default_nettype wire

// ==== tb/tb_jesd_tx_up.sv ====
// ##########################################################################
// Testbench for the JESD204 transmit control plane.
// Drives the register bus, SYNC and sample data and checks registers and lanes.
// ##########################################################################
`timescale 1ns/1ps
`default_nettype none
`include "jesd_tx_cfg.svh"

module tb_jesd_tx_up;

  localparam int LANES = `JESD_NUM_LANES;
  localparam int LANE_W = 32 * LANES;
  localparam int NUM_MF = 2;
  // time budget of the five tests in ns.
  localparam int TEST_NS = 400 + 1000 + 1500 + 600 + 2500;

  logic                       up_clk;
  logic                       up_reset;
  logic [11:0]                up_raddr;
  logic [11:0]                up_waddr;
  logic                       up_wreq;
  logic [31:0]                up_wdata;
  logic [31:0]                up_rdata;
  logic                       up_cfg_is_writeable;
  logic                       core_clk;
  logic                       core_reset;
  logic [`JESD_NUM_LINKS-1:0] sync;
  logic [LANE_W-1:0]          tx_data;
  logic [LANE_W-1:0]          lane_data;
  jesd_tx_pkg::link_state_t   lane_state;

  int          errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  logic [31:0] lcg_state = 32'h34b8;
  // expected ILAS readback holds a shared part per word and a lane part per lane.
  logic [31:0] shared_exp [4];
  logic [31:0] lane_exp [LANES][4];

  jesd_tx_up_top dut0 (
    .up_clk              (up_clk),
    .up_reset            (up_reset),
    .up_raddr            (up_raddr),
    .up_rdata            (up_rdata),
    .up_wreq             (up_wreq),
    .up_waddr            (up_waddr),
    .up_wdata            (up_wdata),
    .up_cfg_is_writeable (up_cfg_is_writeable),
    .core_clk            (core_clk),
    .core_reset          (core_reset),
    .sync                (sync),
    .tx_data             (tx_data),
    .lane_data           (lane_data),
    .lane_state          (lane_state)
  );

  initial begin
    up_clk = 1'b0;
    forever #5 up_clk = ~up_clk;
  end

  initial begin
    core_clk = 1'b0;
    forever #4 core_clk = ~core_clk;
  end

  initial begin
    core_reset = 1'b1;
    repeat (8) @(posedge core_clk);
    core_reset <= 1'b0;
  end

  initial begin
    #(2 * TEST_NS);
    $display("watchdog expired after %0d ns with tests still running", 2 * TEST_NS);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [LANE_W-1:0] random_lanes();
    logic [LANE_W-1:0] v;
    for (int l = 0; l < LANES; l++) begin
      v[l*32 +: 32] = lcg_next();
    end
    return v;
  endfunction

  function automatic int failures();
    return errors + dut0.sva0.fail_count;
  endfunction

  // bits of each configuration word held once for all lanes.
  function automatic logic [31:0] shared_mask(input int word);
    case (word)
      0: return 32'h0FFF_0000;
      1: return 32'h1FFF_9F00;
      2: return 32'hFFFF_DFFF;
      default: return 32'h0000_009F;
    endcase
  endfunction

  // lane id in word 1 and checksum in word 3 are kept per lane.
  function automatic logic [31:0] lane_mask(input int word);
    return (word == 1) ? 32'h0000_001F : (word == 3) ? 32'hFF00_0000 : 32'h0;
  endfunction

  function automatic logic [11:0] ilas_addr(input int lane, input int word);
    return 12'(`JESD_REG_ILAS_BASE + 8 * lane + word);
  endfunction

  // expected lane word during ILAS.
  function automatic logic [31:0] expected_word(input int lane, input int mf, input int beat);
    if (mf == 1) begin
      return shared_exp[beat] | lane_exp[lane][beat];
    end
    if (beat == 0) begin
      return {4{jesd_tx_pkg::K_RSTART}};
    end
    return (beat == 3) ? {4{jesd_tx_pkg::K_AEND}} : 32'h0;
  endfunction

  task automatic check_value(input string name, input logic [LANE_W-1:0] got,
                             input logic [LANE_W-1:0] exp);
    assert (got === exp) else begin
      errors++;
      $display("Error at %0d ns: %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  task automatic bus_write(input logic [11:0] addr, input logic [31:0] data);
    @(posedge up_clk);
    up_waddr <= addr;
    up_wdata <= data;
    up_wreq  <= 1'b1;
    @(posedge up_clk);
    up_wreq  <= 1'b0;
  endtask

  task automatic bus_read(input logic [11:0] addr, output logic [31:0] data);
    @(posedge up_clk);
    up_raddr <= addr;
    @(negedge up_clk);
    data = up_rdata;
  endtask

  task automatic check_reg(input logic [11:0] addr, input logic [31:0] exp);
    logic [31:0] rd;
    bus_read(addr, rd);
    check_value($sformatf("up_rdata[0x%03h]", addr), LANE_W'(rd), LANE_W'(exp));
  endtask

  task automatic ilas_write(input int lane, input int word, input logic [31:0] data);
    bus_write(ilas_addr(lane, word), data);
    shared_exp[word] = data & shared_mask(word);
    lane_exp[lane][word] = data & lane_mask(word);
  endtask

  task automatic wait_state(input jesd_tx_pkg::link_state_t target, input int max_cycles,
                            output bit seen);
    seen = 1'b0;
    for (int n = 0; n < max_cycles && !seen; n++) begin
      @(negedge core_clk);
      seen = (lane_state == target);
    end
    assert (seen) else begin
      errors++;
      $display("link did not reach %s within %0d cycles at %0d ns", target.name(),
               max_cycles, $time);
    end
  endtask

  task automatic poll_status(input jesd_tx_pkg::link_state_t target);
    logic [31:0] rd;
    bit          seen;
    seen = 1'b0;
    for (int n = 0; n < 20 && !seen; n++) begin
      bus_read(`JESD_REG_STATUS, rd);
      seen = (rd[1:0] == target);
    end
    assert (seen) else begin
      errors++;
      $display("status register never showed %s at %0d ns", target.name(), $time);
    end
  endtask

  task automatic finish_test(input string name, input int start);
    tests_run++;
    if (failures() == start) begin
      $display("test %-14s passed", name);
    end else begin
      tests_failed++;
      $display("test %-14s failed with %0d errors", name, failures() - start);
    end
  endtask

  initial begin
    int                start;
    bit                seen;
    bit                saw_ilas;
    logic [LANE_W-1:0] prev;
    up_reset = 1'b1;
    up_raddr = '0;
    up_waddr = '0;
    up_wreq = 1'b0;
    up_wdata = '0;
    up_cfg_is_writeable = 1'b1;
    sync = '0;
    tx_data = '0;
    for (int w = 0; w < 4; w++) begin
      shared_exp[w] = '0;
      for (int l = 0; l < LANES; l++) begin
        lane_exp[l][w] = '0;
      end
    end
    repeat (8) @(posedge up_clk);
    up_reset <= 1'b0;
    repeat (4) @(posedge up_clk);

    start = failures();
    check_reg(`JESD_REG_CFG, 32'h0);
    check_reg(`JESD_REG_MFRAMES, 32'd3);
    check_reg(`JESD_REG_STATUS, 32'h0);
    for (int l = 0; l < LANES; l++) begin
      for (int w = 0; w < 4; w++) begin
        check_reg(ilas_addr(l, w), 32'h0);
      end
    end
    @(negedge core_clk);
    check_value("lane_data", lane_data, {4*LANES{jesd_tx_pkg::K_CGS}});
    finish_test("reset values", start);

    start = failures();
    bus_write(`JESD_REG_CFG, 32'h7);
    check_reg(`JESD_REG_CFG, 32'h7);
    bus_write(`JESD_REG_CFG, 32'h0);
    bus_write(`JESD_REG_MFRAMES, NUM_MF);
    check_reg(`JESD_REG_MFRAMES, NUM_MF);
    // lane ids and checksums go first, then the shared fields through lane 0.
    for (int l = 1; l < LANES; l++) begin
      ilas_write(l, 1, lcg_next());
      ilas_write(l, 3, lcg_next());
    end
    for (int w = 0; w < 4; w++) begin
      ilas_write(0, w, lcg_next());
    end
    for (int l = 0; l < LANES; l++) begin
      for (int w = 0; w < 4; w++) begin
        check_reg(ilas_addr(l, w), shared_exp[w] | lane_exp[l][w]);
      end
    end
    @(posedge up_clk);
    up_cfg_is_writeable <= 1'b0;
    bus_write(`JESD_REG_CFG, 32'h7);
    bus_write(`JESD_REG_MFRAMES, 32'h55);
    bus_write(ilas_addr(1, 1), lcg_next());
    check_reg(`JESD_REG_CFG, 32'h0);
    check_reg(`JESD_REG_MFRAMES, NUM_MF);
    check_reg(ilas_addr(1, 1), shared_exp[1] | lane_exp[1][1]);
    @(posedge up_clk);
    up_cfg_is_writeable <= 1'b1;
    check_reg(12'h000, 32'h0);
    check_reg(12'h093, 32'h0);
    check_reg(12'h0C8, 32'h0);
    check_reg(12'h0D4, 32'h0);
    finish_test("register access", start);

    start = failures();
    @(posedge core_clk);
    sync <= '1;
    wait_state(jesd_tx_pkg::LINK_ILAS, 50, seen);
    if (seen) begin
      for (int j = 0; j < (NUM_MF + 1) * 4; j++) begin
        if (j > 0) begin
          @(negedge core_clk);
        end
        check_value("lane_state", LANE_W'(lane_state), LANE_W'(jesd_tx_pkg::LINK_ILAS));
        for (int l = 0; l < LANES; l++) begin
          check_value($sformatf("lane_data[%0d]", l), LANE_W'(lane_data[l*32 +: 32]),
                      LANE_W'(expected_word(l, j / 4, j % 4)));
        end
      end
      @(negedge core_clk);
      check_value("lane_state", LANE_W'(lane_state), LANE_W'(jesd_tx_pkg::LINK_DATA));
    end
    poll_status(jesd_tx_pkg::LINK_DATA);
    finish_test("ILAS sequence", start);

    start = failures();
    for (int k = 0; k < 16; k++) begin
      @(posedge core_clk);
      prev = tx_data;
      tx_data <= random_lanes();
      @(negedge core_clk);
      check_value("lane_data", lane_data, prev);
    end
    @(posedge core_clk);
    sync <= '0;
    wait_state(jesd_tx_pkg::LINK_CGS, 20, seen);
    check_value("lane_data", lane_data, {4*LANES{jesd_tx_pkg::K_CGS}});
    finish_test("data and sync", start);

    start = failures();
    bus_write(`JESD_REG_CFG, 32'h4);
    // configuration levels cross in at most three core cycles.
    repeat (4) @(posedge core_clk);
    sync <= '1;
    seen = 1'b0;
    saw_ilas = 1'b0;
    for (int n = 0; n < 50 && !seen; n++) begin
      @(negedge core_clk);
      saw_ilas = saw_ilas | (lane_state == jesd_tx_pkg::LINK_ILAS);
      seen = (lane_state == jesd_tx_pkg::LINK_DATA);
    end
    assert (seen && !saw_ilas) else begin
      errors++;
      $display("link with skip_ilas did not go straight from CGS to DATA");
    end
    @(posedge core_clk);
    sync <= '0;
    wait_state(jesd_tx_pkg::LINK_CGS, 20, seen);
    bus_write(`JESD_REG_CFG, 32'h1);
    repeat (4) @(posedge core_clk);
    sync <= '1;
    repeat (40) begin
      @(negedge core_clk);
      check_value("lane_state", LANE_W'(lane_state), LANE_W'(jesd_tx_pkg::LINK_CGS));
    end
    bus_write(`JESD_REG_CFG, 32'h0);
    wait_state(jesd_tx_pkg::LINK_DATA, (NUM_MF + 1) * 4 + 40, seen);
    bus_write(`JESD_REG_SYNC_REQ, 32'h1);
    wait_state(jesd_tx_pkg::LINK_CGS, 20, seen);
    check_value("lane_data", lane_data, {4*LANES{jesd_tx_pkg::K_CGS}});
    finish_test("options", start);

    $display("tests run %0d, tests failed %0d, check errors %0d, assertion errors %0d",
             tests_run, tests_failed, errors, dut0.sva0.fail_count);
    if (failures() == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
